// File: design/hazard_defs.svh
`ifndef HAZARD_DEFS_SVH
`define HAZARD_DEFS_SVH

// datapath widths
`define XLEN            64
`define REG_ADDR_WIDTH  5

// register block address space, byte offsets
`define AXIL_ADDR_WIDTH 4

`define REG_CTRL        4'h0    // fwd_en, memchk_en, clear
`define REG_RAW_STALLS  4'h4    // load-use and no-forward stalls
`define REG_MEM_STALLS  4'h8    // store-to-load stalls

`endif

// File: design/pipe_pkg.sv
`include "hazard_defs.svh"

package pipe_pkg;

    // operand source picked for the decode stage
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_EX   = 2'd1,
        FWD_MEM  = 2'd2,
        FWD_WB   = 2'd3
    } fwd_sel_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_t;

    // one in-flight destination, 8 bits
    typedef struct packed {
        logic                       valid;
        logic                       wen;
        logic                       is_load;    // result late, needs one bubble
        logic [`REG_ADDR_WIDTH-1:0] rd;
    } dest_info_t;

    // pending store, doubleword granularity
    typedef struct packed {
        logic             valid;
        logic [`XLEN-4:0] addr;
    } store_info_t;

endpackage

// File: design/csr_pkg.sv
package csr_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // control register at REG_CTRL
    typedef struct packed {
        logic [28:0] rsvd;
        logic        clr_cnt;   // write one, reads back zero
        logic        memchk_en;
        logic        fwd_en;
    } ctrl_reg_t;

    // reset state of the control bits
    localparam logic CTRL_FWD_EN_RST    = 1'b1;
    localparam logic CTRL_MEMCHK_EN_RST = 1'b1;

    // counter width matches the bus data width
    localparam int CNT_WIDTH = 32;

endpackage

// File: design/stage_shadow.sv
`timescale 1ns/1ps
`include "hazard_defs.svh"

// shift chain that mirrors what sits in EX, MEM, WB
module stage_shadow #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 3
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t advance_in,     // entry leaving decode
    input  logic     hold_bubble,    // decode not accepted this cycle
    output payload_t taps [DEPTH]    // taps[0] is the youngest
);

    payload_t chain_q [DEPTH];
    payload_t head_d;

    // zero payload means an empty slot
    assign head_d = hold_bubble ? payload_t'('0) : advance_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                chain_q[i] <= payload_t'('0);
            end
        end else begin
            chain_q[0] <= head_d;
            // older stages just age by one
            for (int i = 1; i < DEPTH; i++) begin
                chain_q[i] <= chain_q[i-1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            taps[i] = chain_q[i];
        end
    end

endmodule

// File: design/hazard_detect.sv
`timescale 1ns/1ps
`include "hazard_defs.svh"

module hazard_detect import pipe_pkg::*; (
    input  logic                       id_valid,
    input  logic [`REG_ADDR_WIDTH-1:0] id_rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] id_rs2,
    input  logic                       id_use_rs1,
    input  logic                       id_use_rs2,
    input  logic [`REG_ADDR_WIDTH-1:0] id_rd,
    input  logic                       id_wen,
    input  mem_op_t                    id_mem_op,
    input  logic [`XLEN-1:0]           id_base,
    input  logic [`XLEN-1:0]           id_imm,
    input  dest_info_t                 dest_taps [3],   // ex, mem, wb
    input  store_info_t                store_taps [2],  // ex, mem
    input  logic                       fwd_en,
    input  logic                       memchk_en,
    output logic                       stall,
    output logic                       raw_stall,
    output logic                       mem_stall,
    output fwd_sel_t                   fwd_rs1,
    output fwd_sel_t                   fwd_rs2,
    output dest_info_t                 dest_entry,
    output store_info_t                store_entry
);

    logic [2:0]       hit_rs1;  // bit 0 ex, bit 1 mem, bit 2 wb
    logic [2:0]       hit_rs2;
    logic [1:0]       st_hit;
    logic             raw_rs1;
    logic             raw_rs2;
    logic [`XLEN-1:0] eff_addr;
    logic [`XLEN-4:0] eff_dw;
    logic             is_load;

    function automatic logic src_match(input logic                       used,
                                       input logic [`REG_ADDR_WIDTH-1:0] rs,
                                       input dest_info_t                 ent);
        return used && ent.valid && ent.wen && (ent.rd == rs) && (rs != '0);
    endfunction

    // youngest producer wins
    function automatic fwd_sel_t pick_src(input logic [2:0] hit);
        fwd_sel_t sel;
        if (hit[0]) begin
            sel = FWD_EX;
        end else if (hit[1]) begin
            sel = FWD_MEM;
        end else if (hit[2]) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    always_comb begin
        for (int s = 0; s < 3; s++) begin
            hit_rs1[s] = src_match(id_use_rs1, id_rs1, dest_taps[s]);
            hit_rs2[s] = src_match(id_use_rs2, id_rs2, dest_taps[s]);
        end
    end

    // without forwarding every match waits, with it only a load in EX does
    assign raw_rs1 = fwd_en ? (hit_rs1[0] && dest_taps[0].is_load) : |hit_rs1;
    assign raw_rs2 = fwd_en ? (hit_rs2[0] && dest_taps[0].is_load) : |hit_rs2;

    assign raw_stall = id_valid && (raw_rs1 || raw_rs2);

    assign eff_addr = id_base + id_imm;
    assign eff_dw   = eff_addr[`XLEN-1:3];  // doubleword index
    assign is_load  = (id_mem_op == MEM_LOAD);

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            st_hit[s] = store_taps[s].valid && (store_taps[s].addr == eff_dw);
        end
    end

    assign mem_stall = id_valid && memchk_en && is_load && |st_hit;
    assign stall     = raw_stall || mem_stall;

    assign fwd_rs1 = (id_valid && fwd_en && !stall) ? pick_src(hit_rs1) : FWD_NONE;
    assign fwd_rs2 = (id_valid && fwd_en && !stall) ? pick_src(hit_rs2) : FWD_NONE;

    // entries for the shadows, dropped by hold_bubble when not accepted
    assign dest_entry.valid   = id_valid;
    assign dest_entry.wen     = id_wen;
    assign dest_entry.is_load = is_load;
    assign dest_entry.rd      = id_rd;

    assign store_entry.valid = id_valid && (id_mem_op == MEM_STORE);
    assign store_entry.addr  = eff_dw;

endmodule

// File: design/hazard_csr.sv
`timescale 1ns/1ps
`include "hazard_defs.svh"

module hazard_csr import pipe_pkg::*, csr_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`AXIL_ADDR_WIDTH-1:0] awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [31:0]                 wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output axi_resp_t                   bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [31:0]                 rdata,
    output axi_resp_t                   rresp,
    output logic                        rvalid,
    input  logic                        rready,
    input  logic                        raw_stall,
    input  logic                        mem_stall,
    output logic                        fwd_en,
    output logic                        memchk_en
);

    ctrl_reg_t            wr_ctrl;
    ctrl_reg_t            rd_ctrl;
    logic                 wr_fire;
    logic                 rd_fire;
    logic                 clr_cnt;
    axi_resp_t            wr_resp;
    axi_resp_t            rd_resp;
    logic [31:0]          rd_val;
    logic [1:0]           cause;
    logic [CNT_WIDTH-1:0] stall_cnt [2];    // 0 raw, 1 mem

    // one transaction per direction, ready drops while the response waits
    assign awready = !bvalid;
    assign wready  = !bvalid;
    assign arready = !rvalid;

    assign wr_fire = awvalid && wvalid && !bvalid;
    assign rd_fire = arvalid && !rvalid;

    assign wr_ctrl = ctrl_reg_t'(wdata);
    assign clr_cnt = wr_fire && (awaddr == `REG_CTRL) && wr_ctrl.clr_cnt;

    always_comb begin
        case (awaddr)
            `REG_CTRL, `REG_RAW_STALLS, `REG_MEM_STALLS: wr_resp = RESP_OKAY;
            default:                                     wr_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid    <= 1'b0;
            fwd_en    <= CTRL_FWD_EN_RST;
            memchk_en <= CTRL_MEMCHK_EN_RST;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
            if (awaddr == `REG_CTRL) begin
                fwd_en    <= wr_ctrl.fwd_en;
                memchk_en <= wr_ctrl.memchk_en;
            end
        end else if (bready) begin
            bvalid <= 1'b0;     // held until the master takes it
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_resp;
        end
    end

    always_comb begin
        rd_ctrl           = '0;
        rd_ctrl.fwd_en    = fwd_en;
        rd_ctrl.memchk_en = memchk_en;
        rd_resp           = RESP_OKAY;
        case (araddr)
            `REG_CTRL:       rd_val = rd_ctrl;
            `REG_RAW_STALLS: rd_val = stall_cnt[0];
            `REG_MEM_STALLS: rd_val = stall_cnt[1];
            default: begin
                rd_val  = '0;
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_val;
            rresp <= rd_resp;
        end
    end

    assign cause = {mem_stall, raw_stall};

    // saturating counters, clear wins over a count in the same cycle
    for (genvar c = 0; c < 2; c++) begin : g_cnt
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                stall_cnt[c] <= '0;
            end else if (clr_cnt) begin
                stall_cnt[c] <= '0;
            end else if (cause[c] && !(&stall_cnt[c])) begin
                stall_cnt[c] <= stall_cnt[c] + 1'b1;
            end
        end
    end

endmodule

// File: design/hazard_top.sv
`timescale 1ns/1ps
`include "hazard_defs.svh"

module hazard_top import pipe_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        id_valid,
    input  logic [`REG_ADDR_WIDTH-1:0]  id_rs1,
    input  logic [`REG_ADDR_WIDTH-1:0]  id_rs2,
    input  logic                        id_use_rs1,
    input  logic                        id_use_rs2,
    input  logic [`REG_ADDR_WIDTH-1:0]  id_rd,
    input  logic                        id_wen,
    input  mem_op_t                     id_mem_op,
    input  logic [`XLEN-1:0]            id_base,
    input  logic [`XLEN-1:0]            id_imm,
    output logic                        stall,
    output fwd_sel_t                    fwd_rs1,
    output fwd_sel_t                    fwd_rs2,
    input  logic [`AXIL_ADDR_WIDTH-1:0] awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [31:0]                 wdata,
    input  logic [3:0]                  wstrb,      // full-word writes only
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [31:0]                 rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready
);

    dest_info_t  dest_taps [3];
    store_info_t store_taps [2];
    dest_info_t  dest_entry;
    store_info_t store_entry;
    logic        raw_stall;
    logic        mem_stall;
    logic        fwd_en;
    logic        memchk_en;
    logic        hold_bubble;

    // nothing enters EX unless decode is valid and not stalled
    assign hold_bubble = stall || !id_valid;

    hazard_detect u_detect (
        .id_valid    (id_valid),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_use_rs1  (id_use_rs1),
        .id_use_rs2  (id_use_rs2),
        .id_rd       (id_rd),
        .id_wen      (id_wen),
        .id_mem_op   (id_mem_op),
        .id_base     (id_base),
        .id_imm      (id_imm),
        .dest_taps   (dest_taps),
        .store_taps  (store_taps),
        .fwd_en      (fwd_en),
        .memchk_en   (memchk_en),
        .stall       (stall),
        .raw_stall   (raw_stall),
        .mem_stall   (mem_stall),
        .fwd_rs1     (fwd_rs1),
        .fwd_rs2     (fwd_rs2),
        .dest_entry  (dest_entry),
        .store_entry (store_entry)
    );

    stage_shadow #(.payload_t(dest_info_t), .DEPTH(3)) u_dest_shadow (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance_in  (dest_entry),
        .hold_bubble (hold_bubble),
        .taps        (dest_taps)
    );

    stage_shadow #(.payload_t(store_info_t), .DEPTH(2)) u_store_shadow (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance_in  (store_entry),
        .hold_bubble (hold_bubble),
        .taps        (store_taps)
    );

    hazard_csr u_csr (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .raw_stall (raw_stall),
        .mem_stall (mem_stall),
        .fwd_en    (fwd_en),
        .memchk_en (memchk_en)
    );

endmodule

// File: tests/tb_hazard.sv
`timescale 1ns/1ps
`include "hazard_defs.svh"

module tb_hazard import pipe_pkg::*, csr_pkg::*;;

    localparam int N_RANDOM   = 300;
    localparam int N_DIRECTED = 40;

    typedef struct packed {
        logic                       valid;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic                       use1;
        logic                       use2;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       wen;
        mem_op_t                    op;
        logic [`XLEN-1:0]           base;
        logic [`XLEN-1:0]           imm;
    } instr_t;

    typedef struct packed {
        logic     stall;
        logic     raw;
        logic     mem;
        fwd_sel_t f1;
        fwd_sel_t f2;
    } exp_t;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic id_valid, id_use_rs1, id_use_rs2, id_wen;
    logic [`REG_ADDR_WIDTH-1:0] id_rs1, id_rs2, id_rd;
    mem_op_t id_mem_op;
    logic [`XLEN-1:0] id_base, id_imm;
    logic stall;
    fwd_sel_t fwd_rs1, fwd_rs2;
    logic [`AXIL_ADDR_WIDTH-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;

    // model state, index 0 is EX
    dest_info_t  [2:0] m_dest = '0;
    store_info_t [1:0] m_store = '0;
    logic m_fwd_en = 1'b1;
    logic m_memchk_en = 1'b1;
    int exp_raw_cnt = 0;
    int exp_mem_cnt = 0;
    int check_errs = 0;
    int other_errs = 0;
    integer seed = 32'ha4b6_f19c;

    hazard_top dut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            check_errs++;
            $display("CHECK FAILED t=%0t %s expected %0h got %0h", $time, what, exp, act);
        end
    endtask

    // expected outputs straight from the detection rules
    function automatic exp_t ref_hazard(input dest_info_t [2:0] d, input store_info_t [1:0] s,
                                        input logic fen, input logic men, input instr_t ins);
        exp_t r;
        fwd_sel_t sel [2];
        logic [`REG_ADDR_WIDTH-1:0] src [2];
        logic used [2];
        logic [`XLEN-1:0] ea;
        r = '0;
        src[0] = ins.rs1;
        src[1] = ins.rs2;
        used[0] = ins.use1;
        used[1] = ins.use2;
        if (!ins.valid) begin
            return r;
        end
        for (int k = 0; k < 2; k++) begin
            sel[k] = FWD_NONE;
            // oldest first, a younger hit overwrites
            for (int st = 2; st >= 0; st--) begin
                if (used[k] && src[k] != 0 && d[st].valid && d[st].wen && d[st].rd == src[k]) begin
                    if (!fen || (st == 0 && d[st].is_load)) r.raw = 1'b1;
                    sel[k] = fwd_sel_t'(st + 1);
                end
            end
        end
        ea = ins.base + ins.imm;
        if (men && ins.op == MEM_LOAD) begin
            for (int st = 0; st < 2; st++) begin
                if (s[st].valid && s[st].addr == ea[`XLEN-1:3]) r.mem = 1'b1;
            end
        end
        r.stall = r.raw | r.mem;
        if (fen && !r.stall) begin
            r.f1 = sel[0];
            r.f2 = sel[1];
        end
        return r;
    endfunction

    // compare before each edge, then age the model
    initial begin
        exp_t e;
        instr_t cur;
        logic take;
        logic [`XLEN-1:0] ea;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            cur = {id_valid, id_rs1, id_rs2, id_use_rs1, id_use_rs2, id_rd, id_wen, id_mem_op,
                   id_base, id_imm};
            e = ref_hazard(m_dest, m_store, m_fwd_en, m_memchk_en, cur);
            check_eq("stall", 64'(e.stall), 64'(stall));
            check_eq("fwd_rs1", 64'(e.f1), 64'(fwd_rs1));
            check_eq("fwd_rs2", 64'(e.f2), 64'(fwd_rs2));
            if (e.raw) exp_raw_cnt++;
            if (e.mem) exp_mem_cnt++;
            take = cur.valid && !e.stall;
            ea = cur.base + cur.imm;
            @(posedge clk);
            m_dest[2:1] = m_dest[1:0];
            m_store[1] = m_store[0];
            m_dest[0] = '0;     // bubble unless accepted
            m_store[0] = '0;
            if (take) begin
                m_dest[0] = '{valid: 1'b1, wen: cur.wen, is_load: cur.op == MEM_LOAD, rd: cur.rd};
                m_store[0] = '{valid: cur.op == MEM_STORE, addr: ea[`XLEN-1:3]};
            end
        end
    end

    initial begin
        repeat ((N_RANDOM + N_DIRECTED) * 10 + 400) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic instr_t alu_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return '{valid: 1'b1, rs1: rs1, rs2: rs2, use1: 1'b1, use2: 1'b1, rd: rd,
                 wen: 1'b1, op: MEM_NONE, base: '0, imm: '0};
    endfunction

    function automatic instr_t load_instr(input logic [4:0] rd, input logic [63:0] base,
                                          input logic [63:0] imm);
        return '{valid: 1'b1, rs1: 5'd0, rs2: 5'd0, use1: 1'b1, use2: 1'b0, rd: rd,
                 wen: 1'b1, op: MEM_LOAD, base: base, imm: imm};
    endfunction

    function automatic instr_t store_instr(input logic [63:0] base, input logic [63:0] imm);
        return '{valid: 1'b1, rs1: 5'd0, rs2: 5'd0, use1: 1'b1, use2: 1'b1, rd: 5'd0,
                 wen: 1'b0, op: MEM_STORE, base: base, imm: imm};
    endfunction

    // present one instruction until decode accepts it
    task automatic send_instr(input instr_t ins, output int stalls, output fwd_sel_t f1,
                              output fwd_sel_t f2);
        logic held;
        stalls = 0;
        id_valid <= 1'b1;
        id_rs1 <= ins.rs1;
        id_rs2 <= ins.rs2;
        id_use_rs1 <= ins.use1;
        id_use_rs2 <= ins.use2;
        id_rd <= ins.rd;
        id_wen <= ins.wen;
        id_mem_op <= ins.op;
        id_base <= ins.base;
        id_imm <= ins.imm;
        held = 1'b1;
        while (held) begin
            @(negedge clk);
            held = stall;
            f1 = fwd_rs1;
            f2 = fwd_rs2;
            if (held) stalls++;
            @(posedge clk);
            assert (stalls <= 6) else begin
                other_errs++;
                $display("decode stayed stalled for more than six cycles at %0t", $time);
                held = 1'b0;
            end
        end
        id_valid <= 1'b0;
    endtask

    task automatic issue_and_check(input instr_t ins, input int exp_stalls,
                                   input fwd_sel_t exp_f1, input fwd_sel_t exp_f2);
        int n;
        fwd_sel_t f1;
        fwd_sel_t f2;
        send_instr(ins, n, f1, f2);
        check_eq("stall cycles", 64'(exp_stalls), 64'(n));
        check_eq("fwd_rs1 at issue", 64'(exp_f1), 64'(f1));
        check_eq("fwd_rs2 at issue", 64'(exp_f2), 64'(f2));
    endtask

    task automatic idle_cycles(input int n);
        id_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        int n;
        awaddr <= addr;
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        bready <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!(awready && wready) && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (awready && wready) else begin
            other_errs++;
            $display("write address or data channel never became ready at %0t", $time);
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!bvalid && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (bvalid) else begin
            other_errs++;
            $display("no write response for offset %0h", addr);
        end
        if (bvalid) begin
            check_eq("bresp", 64'(exp_resp), 64'(bresp));
            // both write channels closed while the response waits
            check_eq("awready", 64'd0, 64'(awready));
            check_eq("wready", 64'd0, 64'(wready));
        end
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
        int n;
        araddr <= addr;
        arvalid <= 1'b1;
        rready <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (arready) else begin
            other_errs++;
            $display("read address channel never became ready at %0t", $time);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!rvalid && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (rvalid) else begin
            other_errs++;
            $display("no read response for offset %0h", addr);
        end
        if (rvalid) begin
            check_eq("rdata", 64'(exp_data), 64'(rdata));
            check_eq("rresp", 64'(exp_resp), 64'(rresp));
            check_eq("arready", 64'd0, 64'(arready));
        end
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic set_ctrl(input logic [31:0] data);
        axi_write(`REG_CTRL, data, RESP_OKAY);
        m_fwd_en = data[0];
        m_memchk_en = data[1];
        if (data[2]) begin
            exp_raw_cnt = 0;
            exp_mem_cnt = 0;
        end
    endtask

    initial begin
        instr_t ins;
        logic [31:0] rnd;
        logic [31:0] modes [3];
        int n;
        fwd_sel_t f1;
        fwd_sel_t f2;
        modes = '{32'h3, 32'h1, 32'h2};
        id_valid = 1'b0;
        id_rs1 = '0;
        id_rs2 = '0;
        id_use_rs1 = 1'b0;
        id_use_rs2 = 1'b0;
        id_rd = '0;
        id_wen = 1'b0;
        id_mem_op = MEM_NONE;
        id_base = '0;
        id_imm = '0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = 4'hf;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        axi_read(`REG_CTRL, 32'h3, RESP_OKAY);
        axi_read(`REG_RAW_STALLS, 32'h0, RESP_OKAY);
        axi_read(`REG_MEM_STALLS, 32'h0, RESP_OKAY);
        axi_read(4'hc, 32'h0, RESP_SLVERR);
        axi_write(4'hc, 32'h5, RESP_SLVERR);

        // producer ages through ex, mem, wb
        issue_and_check(alu_instr(5'd5, 5'd1, 5'd2), 0, FWD_NONE, FWD_NONE);
        issue_and_check(alu_instr(5'd6, 5'd5, 5'd0), 0, FWD_EX, FWD_NONE);
        issue_and_check(alu_instr(5'd7, 5'd5, 5'd0), 0, FWD_MEM, FWD_NONE);
        issue_and_check(alu_instr(5'd8, 5'd0, 5'd5), 0, FWD_NONE, FWD_WB);
        issue_and_check(alu_instr(5'd0, 5'd1, 5'd2), 0, FWD_NONE, FWD_NONE);
        issue_and_check(alu_instr(5'd9, 5'd0, 5'd3), 0, FWD_NONE, FWD_NONE);
        ins = alu_instr(5'd10, 5'd9, 5'd9);
        ins.use1 = 1'b0;
        ins.use2 = 1'b0;
        issue_and_check(ins, 0, FWD_NONE, FWD_NONE);
        idle_cycles(4);

        // load-use, one bubble then mem
        issue_and_check(load_instr(5'd11, 64'h100, 64'h8), 0, FWD_NONE, FWD_NONE);
        issue_and_check(alu_instr(5'd12, 5'd11, 5'd2), 1, FWD_MEM, FWD_NONE);
        idle_cycles(4);

        set_ctrl(32'h2);
        issue_and_check(alu_instr(5'd13, 5'd1, 5'd2), 0, FWD_NONE, FWD_NONE);
        issue_and_check(alu_instr(5'd14, 5'd13, 5'd0), 3, FWD_NONE, FWD_NONE);
        idle_cycles(4);
        set_ctrl(32'h3);

        // store then load on the same and on another doubleword
        issue_and_check(store_instr(64'h2000, 64'h10), 0, FWD_NONE, FWD_NONE);
        issue_and_check(load_instr(5'd15, 64'h2008, 64'h8), 2, FWD_NONE, FWD_NONE);
        issue_and_check(store_instr(64'h3000, 64'h0), 0, FWD_NONE, FWD_NONE);
        issue_and_check(load_instr(5'd16, 64'h3008, 64'h0), 0, FWD_NONE, FWD_NONE);
        issue_and_check(load_instr(5'd17, 64'h3000, 64'h4), 1, FWD_NONE, FWD_NONE);
        idle_cycles(4);
        set_ctrl(32'h1);
        issue_and_check(store_instr(64'h4000, 64'h0), 0, FWD_NONE, FWD_NONE);
        issue_and_check(load_instr(5'd18, 64'h4000, 64'h0), 0, FWD_NONE, FWD_NONE);
        idle_cycles(4);

        axi_read(`REG_RAW_STALLS, 32'(exp_raw_cnt), RESP_OKAY);
        axi_read(`REG_MEM_STALLS, 32'(exp_mem_cnt), RESP_OKAY);
        set_ctrl(32'h7);
        axi_read(`REG_CTRL, 32'h3, RESP_OKAY);   // clear bit reads back zero
        axi_read(`REG_RAW_STALLS, 32'h0, RESP_OKAY);
        axi_read(`REG_MEM_STALLS, 32'h0, RESP_OKAY);

        // random run, small register and address ranges for many hits
        for (int m = 0; m < 3; m++) begin
            set_ctrl(modes[m]);
            for (int i = 0; i < N_RANDOM / 3; i++) begin
                rnd = $random(seed);
                ins.valid = 1'b1;
                ins.rs1 = {2'b00, rnd[2:0]};
                ins.rs2 = {2'b00, rnd[5:3]};
                ins.use1 = rnd[6];
                ins.use2 = rnd[7];
                ins.op = (rnd[9:8] == 2'd1) ? MEM_LOAD : (rnd[9:8] == 2'd2) ? MEM_STORE : MEM_NONE;
                ins.rd = {2'b00, rnd[12:10]};
                ins.wen = (ins.op != MEM_STORE);
                ins.base = 64'h1000 + 64'(rnd[17:13]);
                ins.imm = 64'(rnd[20:18]);
                send_instr(ins, n, f1, f2);
                if (rnd[23:21] == 3'd0) idle_cycles(1);
            end
            idle_cycles(4);
        end
        axi_read(`REG_RAW_STALLS, 32'(exp_raw_cnt), RESP_OKAY);
        axi_read(`REG_MEM_STALLS, 32'(exp_mem_cnt), RESP_OKAY);
        idle_cycles(2);

        $display("check errors: %0d, other errors: %0d", check_errs, other_errs);
        if (check_errs == 0 && other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+design
design/pipe_pkg.sv
design/csr_pkg.sv
design/stage_shadow.sv
design/hazard_detect.sv
design/hazard_csr.sv
design/hazard_top.sv
tests/tb_hazard.sv

// File: Makefile
TOP := tb_hazard

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
